// File: src/gmii_rx_pkg.sv
////////////////////
// shared word formats and Ethernet constants for the GMII receive front end
// referenced by scoped name from every stage
////////////////////

package gmii_rx_pkg;

    ////////////////////
    // Ethernet constants
    ////////////////////

    // frame byte count width, destination address through FCS
    localparam int LEN_W = 11;

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // CRC-32 remainder after a correct FCS, normal bit order
    localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

    ////////////////////
    // stage words
    ////////////////////

    // marker output, flag set on first and last byte of a burst
    typedef struct packed {
        logic       boundary;
        logic [7:0] data;
    } boundary_word_t;

    // stripped payload with explicit frame delimiters
    typedef struct packed {
        logic       sof;
        logic       eof;
        logic [7:0] data;
    } payload_word_t;

    // per-frame result
    typedef struct packed {
        logic [LEN_W-1:0] byte_count;
        logic             crc_ok;
        logic             runt;
        logic             oversize;
    } frame_status_t;

endpackage

// File: src/frame_boundary_marker.sv
////////////////////
// registers the GMII receive byte and flags the first and last byte of each burst
// output lags the dv pattern by two cycles
////////////////////

module frame_boundary_marker (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_data_wr,
    input  logic [7:0]                  i_data,
    output logic                        o_data_wr,
    output gmii_rx_pkg::boundary_word_t o_data
);

    typedef enum logic {
        ST_IDLE,
        ST_XFER
    } state_t;

    state_t     state;
    logic       data_wr_d;
    logic [7:0] data_d;
    logic       head_pend;
    logic       burst_end;

    ////////////////////
    // input register
    ////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            data_wr_d <= 1'b0;
        end else begin
            data_wr_d <= i_data_wr;
        end
    end

    always_ff @(posedge i_clk) begin
        data_d <= i_data;
    end

    // dv dropped while the held byte is still valid
    assign burst_end = data_wr_d && !i_data_wr;

    ////////////////////
    // head/tail FSM
    ////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= ST_IDLE;
            head_pend <= 1'b0;
            o_data_wr <= 1'b0;
            o_data    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // one cycle to confirm the burst before forwarding
                    o_data_wr <= 1'b0;
                    o_data    <= '0;
                    head_pend <= i_data_wr;
                    if (i_data_wr) begin
                        state <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    head_pend       <= 1'b0;
                    o_data_wr       <= data_wr_d;
                    o_data.data     <= data_d;
                    // a one-byte burst gets a single flagged word
                    o_data.boundary <= head_pend || burst_end;
                    if (burst_end) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // flag only on the first strobed word and on the word before dv fell
    a_boundary_ends: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_data_wr |-> (o_data.boundary == (!$past(o_data_wr) || !$past(i_data_wr)))
    );

endmodule

// File: src/preamble_stripper.sv
////////////////////
// strips preamble and SFD, turns the boundary flag into sof/eof
// frames with a bad preamble are dropped and flagged at their tail
////////////////////

module preamble_stripper (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_word_wr,
    input  gmii_rx_pkg::boundary_word_t i_word,
    output logic                        o_word_wr,
    output gmii_rx_pkg::payload_word_t  o_word,
    output logic                        o_preamble_err
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_PRE,
        PH_DATA,
        PH_BAD
    } phase_t;

    localparam logic [2:0] PRE_MAX = 3'd7;

    phase_t     phase;
    phase_t     cur_phase;
    logic [2:0] pre_cnt;
    logic [2:0] cur_cnt;
    logic       in_frame;
    logic       is_head;
    logic       is_tail;
    logic       sof_pend;
    logic       out_open;

    // boundary flag meaning depends on whether a frame is open
    assign in_frame  = (phase != PH_IDLE);
    assign is_head   = i_word.boundary && !in_frame;
    assign is_tail   = i_word.boundary && in_frame;
    assign cur_phase = is_head ? PH_PRE : phase;
    assign cur_cnt   = is_head ? 3'd0 : pre_cnt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase          <= PH_IDLE;
            pre_cnt        <= 3'd0;
            sof_pend       <= 1'b0;
            o_word_wr      <= 1'b0;
            o_word         <= '0;
            o_preamble_err <= 1'b0;
        end else begin
            o_word_wr      <= 1'b0;
            o_preamble_err <= 1'b0;
            if (i_word_wr) begin
                case (cur_phase)
                    PH_PRE: begin
                        if (is_tail) begin
                            // burst over before any payload
                            o_preamble_err <= 1'b1;
                            phase          <= PH_IDLE;
                        end else if (i_word.data == gmii_rx_pkg::SFD_BYTE) begin
                            phase    <= PH_DATA;
                            sof_pend <= 1'b1;
                        end else if (i_word.data == gmii_rx_pkg::PREAMBLE_BYTE &&
                                     cur_cnt != PRE_MAX) begin
                            phase   <= PH_PRE;
                            pre_cnt <= cur_cnt + 3'd1;
                        end else begin
                            phase <= PH_BAD;
                        end
                    end
                    PH_DATA: begin
                        o_word_wr   <= 1'b1;
                        o_word.sof  <= sof_pend;
                        o_word.eof  <= is_tail;
                        o_word.data <= i_word.data;
                        sof_pend    <= 1'b0;
                        if (is_tail) begin
                            phase <= PH_IDLE;
                        end
                    end
                    PH_BAD: begin
                        // silent until the tail
                        if (is_tail) begin
                            o_preamble_err <= 1'b1;
                            phase          <= PH_IDLE;
                        end
                    end
                    default: begin
                        // stray word outside a frame
                        phase <= PH_IDLE;
                    end
                endcase
            end else if (in_frame) begin
                // strobe gap with no tail, only a one-byte burst ends this way
                o_preamble_err <= 1'b1;
                phase          <= PH_IDLE;
            end
        end
    end

    ////////////////////
    // output framing check
    ////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            out_open <= 1'b0;
        end else if (o_word_wr) begin
            out_open <= o_word.sof ? !o_word.eof : (out_open && !o_word.eof);
        end
    end

    a_sof_once: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_word_wr && o_word.sof) |-> !out_open
    );

    a_eof_once: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_word_wr && o_word.eof) |-> (out_open || o_word.sof)
    );

endmodule

// File: src/fcs_checker.sv
////////////////////
// CRC-32 and length check over each payload frame
// one status word per frame, a cycle after eof
////////////////////

module fcs_checker #(
    parameter int MIN_FRAME_LEN = 64,
    parameter int MAX_FRAME_LEN = 1518
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_word_wr,
    input  gmii_rx_pkg::payload_word_t i_word,
    output logic                       o_status_wr,
    output gmii_rx_pkg::frame_status_t o_status
);

    localparam int LW = gmii_rx_pkg::LEN_W;

    // reflected form of the 802.3 polynomial
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;

    localparam logic [LW-1:0] LEN_MIN = LW'(MIN_FRAME_LEN);
    localparam logic [LW-1:0] LEN_MAX = LW'(MAX_FRAME_LEN);
    // count sticks one past the maximum
    localparam logic [LW-1:0] LEN_SAT = LW'(MAX_FRAME_LEN + 1);

    logic [31:0]   crc_q;
    logic [31:0]   crc_base;
    logic [31:0]   crc_next;
    logic [31:0]   crc_norm;
    logic [LW-1:0] cnt_q;
    logic [LW-1:0] cnt_base;
    logic [LW-1:0] cnt_next;

    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc;
        // lsb first, as bits go on the wire
        for (int i = 0; i < 8; i++) begin
            c = (c[0] ^ data[i]) ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    // sof restarts both from the preset
    assign crc_base = i_word.sof ? 32'hFFFF_FFFF : crc_q;
    assign cnt_base = i_word.sof ? '0 : cnt_q;
    assign crc_next = crc32_byte(crc_base, i_word.data);
    assign cnt_next = (cnt_base >= LEN_SAT) ? LEN_SAT : cnt_base + 1'b1;

    // register runs reflected, residue is held in normal bit order
    assign crc_norm = {<<{crc_next}};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            crc_q       <= 32'hFFFF_FFFF;
            cnt_q       <= '0;
            o_status_wr <= 1'b0;
            o_status    <= '0;
        end else begin
            o_status_wr <= 1'b0;
            if (i_word_wr) begin
                crc_q <= crc_next;
                cnt_q <= cnt_next;
                if (i_word.eof) begin
                    o_status_wr         <= 1'b1;
                    o_status.byte_count <= cnt_next;
                    o_status.crc_ok     <= (crc_norm == gmii_rx_pkg::CRC_RESIDUE);
                    o_status.runt       <= (cnt_next < LEN_MIN);
                    o_status.oversize   <= (cnt_next > LEN_MAX);
                end
            end
        end
    end

    // frames are at least two payload bytes apart at eof
    a_status_single: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_status_wr |=> !o_status_wr
    );

endmodule

// File: src/gmii_rx_top.sv
////////////////////
// GMII receive front end, marker -> preamble stripper -> FCS checker
////////////////////

module gmii_rx_top #(
    parameter int MIN_FRAME_LEN = 64,
    parameter int MAX_FRAME_LEN = 1518
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_gmii_dv,
    input  logic [7:0]                 i_gmii_data,
    output logic                       o_payload_wr,
    output gmii_rx_pkg::payload_word_t o_payload,
    output logic                       o_status_wr,
    output gmii_rx_pkg::frame_status_t o_status,
    output logic                       o_preamble_err
);

    // marker to stripper
    logic                        mark_wr;
    gmii_rx_pkg::boundary_word_t mark_word;

    frame_boundary_marker marker_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data_wr (i_gmii_dv),
        .i_data    (i_gmii_data),
        .o_data_wr (mark_wr),
        .o_data    (mark_word)
    );

    // payload stream also leaves the block here
    preamble_stripper stripper_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_word_wr      (mark_wr),
        .i_word         (mark_word),
        .o_word_wr      (o_payload_wr),
        .o_word         (o_payload),
        .o_preamble_err (o_preamble_err)
    );

    fcs_checker #(
        .MIN_FRAME_LEN (MIN_FRAME_LEN),
        .MAX_FRAME_LEN (MAX_FRAME_LEN)
    ) checker_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_word_wr   (o_payload_wr),
        .i_word      (o_payload),
        .o_status_wr (o_status_wr),
        .o_status    (o_status)
    );

endmodule

// File: dv/tb_clock_gen.sv
////////////////////
// 100 ns clock and active-low reset for the testbench
// reset held for the first 16 cycles
////////////////////

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

// File: dv/gmii_rx_tb.sv
////////////////////
// testbench for the GMII receive front end
// sends frames on falling edges, queues expected words, checks with assertions
////////////////////

module gmii_rx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MIN_LEN = 64;
    localparam int MAX_LEN = 1518;

    typedef logic [7:0] byte_q_t[$];

    logic                       clk;
    logic                       rst_n;
    logic                       gmii_dv;
    logic [7:0]                 gmii_data;
    logic                       payload_wr;
    gmii_rx_pkg::payload_word_t payload;
    logic                       status_wr;
    gmii_rx_pkg::frame_status_t status;
    logic                       preamble_err;

    // expected results in arrival order
    gmii_rx_pkg::payload_word_t exp_payload_q[$];
    gmii_rx_pkg::frame_status_t exp_status_q[$];
    int                         perr_pending = 0;

    // expectation for the word now on the outputs
    gmii_rx_pkg::payload_word_t payload_exp = '0;
    gmii_rx_pkg::frame_status_t status_exp = '0;
    logic                       payload_have = 1'b0;
    logic                       status_have = 1'b0;
    logic                       perr_ok = 1'b0;
    logic                       traffic_seen = 1'b0;
    bit                         timed_out = 1'b0;

    int seed;
    int payload_errors = 0;
    int status_errors = 0;
    int other_errors = 0;

    tb_clock_gen clock_gen_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    gmii_rx_top #(
        .MIN_FRAME_LEN (MIN_LEN),
        .MAX_FRAME_LEN (MAX_LEN)
    ) dut_i (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_gmii_dv      (gmii_dv),
        .i_gmii_data    (gmii_data),
        .o_payload_wr   (payload_wr),
        .o_payload      (payload),
        .o_status_wr    (status_wr),
        .o_status       (status),
        .o_preamble_err (preamble_err)
    );

    ////////////////////
    // scoreboard
    ////////////////////

    // queue heads taken while the outputs are stable
    always @(negedge clk) begin
        payload_have = 1'b0;
        status_have  = 1'b0;
        perr_ok      = 1'b0;
        if (payload_wr && exp_payload_q.size() > 0) begin
            payload_exp  = exp_payload_q.pop_front();
            payload_have = 1'b1;
        end
        if (status_wr && exp_status_q.size() > 0) begin
            status_exp  = exp_status_q.pop_front();
            status_have = 1'b1;
        end
        if (preamble_err && perr_pending > 0) begin
            perr_pending = perr_pending - 1;
            perr_ok      = 1'b1;
        end
    end

    a_reset_clear: assert property (@(posedge clk)
        !rst_n |-> (!payload_wr && !status_wr && !preamble_err && payload == '0 && status == '0)
    ) else begin
        other_errors++;
        $display("outputs not cleared while reset is asserted");
    end

    a_quiet_before_traffic: assert property (@(posedge clk) disable iff (!rst_n)
        !traffic_seen |-> (!payload_wr && !status_wr && !preamble_err)
    ) else begin
        other_errors++;
        $display("output activity before the first frame was sent");
    end

    a_payload_expected: assert property (@(posedge clk) disable iff (!rst_n)
        payload_wr |-> payload_have
    ) else begin
        payload_errors++;
        $display("payload word %h arrived with none expected", $sampled(payload));
    end

    a_payload_match: assert property (@(posedge clk) disable iff (!rst_n)
        (payload_wr && payload_have) |-> (payload == payload_exp)
    ) else begin
        payload_errors++;
        $display("FAIL o_payload: got %h expected %h", $sampled(payload), $sampled(payload_exp));
    end

    a_status_expected: assert property (@(posedge clk) disable iff (!rst_n)
        status_wr |-> status_have
    ) else begin
        status_errors++;
        $display("status word %h arrived with none expected", $sampled(status));
    end

    a_status_match: assert property (@(posedge clk) disable iff (!rst_n)
        (status_wr && status_have) |-> (status == status_exp)
    ) else begin
        status_errors++;
        $display("FAIL o_status: got %h expected %h", $sampled(status), $sampled(status_exp));
    end

    a_preamble_err_expected: assert property (@(posedge clk) disable iff (!rst_n)
        preamble_err |-> perr_ok
    ) else begin
        other_errors++;
        $display("preamble error pulse on a frame with a good preamble");
    end

    ////////////////////
    // helpers
    ////////////////////

    // reflected CRC-32 with the LSB of each byte first and the result inverted
    function automatic logic [31:0] fcs_of(input byte_q_t bytes);
        logic [31:0] r;
        r = 32'hFFFF_FFFF;
        foreach (bytes[i]) begin
            r = r ^ {24'h0, bytes[i]};
            for (int b = 0; b < 8; b++) begin
                if (r[0]) begin
                    r = (r >> 1) ^ 32'hEDB8_8320;
                end else begin
                    r = r >> 1;
                end
            end
        end
        return ~r;
    endfunction

    function automatic int outstanding_count();
        return exp_payload_q.size() + exp_status_q.size() + perr_pending;
    endfunction

    task automatic report_and_finish();
        $display("errors: payload %0d, status %0d, other %0d",
                 payload_errors, status_errors, other_errors);
        if (payload_errors + status_errors + other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic drive_byte(input logic [7:0] value);
        @(negedge clk);
        traffic_seen = 1'b1;
        gmii_dv      = 1'b1;
        gmii_data    = value;
    endtask

    // frame_len counts destination address through FCS
    task automatic send_frame(input int frame_len, input bit flip_fcs, input int bad_pre_idx,
                              input int idle_cycles);
        byte_q_t                    body;
        logic [31:0]                fcs;
        gmii_rx_pkg::payload_word_t pw;
        gmii_rx_pkg::frame_status_t st;
        int                         cnt;
        if (timed_out) begin
            return;
        end
        for (int i = 0; i < frame_len - 4; i++) begin
            body.push_back(8'($random(seed)));
        end
        fcs = fcs_of(body);
        if (flip_fcs) begin
            fcs = fcs ^ 32'h0000_0100;
        end
        for (int i = 0; i < 4; i++) begin
            body.push_back(fcs[8*i +: 8]);
        end
        if (bad_pre_idx < 0) begin
            foreach (body[i]) begin
                pw.sof  = (i == 0);
                pw.eof  = (i == body.size() - 1);
                pw.data = body[i];
                exp_payload_q.push_back(pw);
            end
            // count sticks one past the maximum
            cnt           = (frame_len > MAX_LEN + 1) ? MAX_LEN + 1 : frame_len;
            st.byte_count = cnt[gmii_rx_pkg::LEN_W-1:0];
            st.crc_ok     = !flip_fcs;
            st.runt       = (frame_len < MIN_LEN);
            st.oversize   = (frame_len > MAX_LEN);
            exp_status_q.push_back(st);
        end else begin
            perr_pending = perr_pending + 1;
        end
        for (int i = 0; i < 7; i++) begin
            drive_byte((i == bad_pre_idx) ? 8'h5A : gmii_rx_pkg::PREAMBLE_BYTE);
        end
        drive_byte(gmii_rx_pkg::SFD_BYTE);
        foreach (body[i]) begin
            drive_byte(body[i]);
        end
        repeat (idle_cycles) begin
            @(negedge clk);
            gmii_dv   = 1'b0;
            gmii_data = 8'h00;
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int cycles;
        cycles = 0;
        if (timed_out) begin
            return;
        end
        while (outstanding_count() > 0 && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (outstanding_count() > 0) begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout with %0d payload words, %0d status words, %0d error pulses missing",
                     exp_payload_q.size(), exp_status_q.size(), perr_pending);
        end else begin
            // let the last checks sample
            repeat (3) @(negedge clk);
        end
    endtask

    task automatic wait_reset_release(input int max_cycles);
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout waiting for reset release");
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        int len;
        gmii_dv   = 1'b0;
        gmii_data = 8'h00;
        seed      = 53;
        wait_reset_release(100);
        // idle stretch before the first frame
        repeat (20) @(negedge clk);

        send_frame(64, 1'b0, -1, 12);
        wait_drain(1000);
        send_frame(64, 1'b1, -1, 12);
        wait_drain(1000);
        send_frame(40, 1'b0, -1, 12);
        wait_drain(1000);
        send_frame(1522, 1'b0, -1, 12);
        wait_drain(4000);
        // fourth preamble byte corrupted
        send_frame(64, 1'b0, 3, 12);
        wait_drain(1000);

        // back-to-back frames with no drain in between
        for (int f = 0; f < 10; f++) begin
            len = 64 + (($random(seed) & 32'h7FFF_FFFF) % 237);
            send_frame(len, 1'b0, -1, 12);
        end
        wait_drain(5000);

        report_and_finish();
    end

endmodule

// File: gmii_rx_top.f
src/gmii_rx_pkg.sv
src/frame_boundary_marker.sv
src/preamble_stripper.sv
src/fcs_checker.sv
src/gmii_rx_top.sv
dv/tb_clock_gen.sv
dv/gmii_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the GMII receive front end with its testbench and runs it under Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f gmii_rx_top.f --top-module gmii_rx_tb -Mdir obj_dir -o gmii_rx_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/gmii_rx_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TB PASSED$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
